//--- all.f
+incdir+include
src/gfx_pixel_pkg.sv
src/gfx_ctrl_pkg.sv
src/gfx_regs.sv
src/pattern_gen.sv
src/fb_writer.sv
src/dbuf_mem.sv
src/scanout.sv
src/gfx_demo.sv
verification/tb_gfx_demo.sv

//--- include/gfx_defines.svh
`ifndef GFX_DEFINES_SVH
`define GFX_DEFINES_SVH

// visible frame size in pixels
`define GFX_FB_WIDTH      16
`define GFX_FB_HEIGHT     12

// horizontal raster, clocks per line including blanking
`define GFX_H_TOTAL       20
`define GFX_H_SYNC_START  17
// exclusive end of the hsync window
`define GFX_H_SYNC_END    19

// vertical raster, lines per frame including blanking
`define GFX_V_TOTAL       14
`define GFX_V_SYNC_LINE   13

// 4 bits each of red, green, blue
`define GFX_PIXEL_BITS    12

// register byte offsets on the APB bus
`define GFX_REG_CTRL      8'h00
`define GFX_REG_FILL      8'h04
`define GFX_REG_STATUS    8'h08

`endif

//--- src/dbuf_mem.sv
`timescale 1ns/1ps

module dbuf_mem
  import gfx_ctrl_pkg::*;
  import gfx_pixel_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       wr_en,
  input  fb_addr_t   wr_addr,
  input  pixel_t     wr_data,
  input  fb_addr_t   rd_addr,
  input  logic       frame_start,
  input  logic       frame_done,
  input  logic       draw_start,
  output pixel_t     rd_data,
  output logic       back_locked,
  output logic       busy,
  output logic       displaying,
  output logic [7:0] swap_count
);

  dbuf_state_t state;
  logic        front_sel;
  logic        front_sel_nxt;
  logic        swap;
  logic        frame_done_q;
  logic        done_rise;

  // index 0 or 1, front_sel names the buffer on screen
  pixel_t mem [2][FB_PIXELS];

  // rising edge of the writer's completion flag
  assign done_rise = frame_done & ~frame_done_q;

  // swap only at a frame boundary, never mid-scan
  assign swap          = (state == DB_SWAP_WAIT) & frame_start;
  assign front_sel_nxt = swap ? ~front_sel : front_sel;

  assign back_locked = (state == DB_SWAP_WAIT);
  // draw_start term makes busy rise on the same edge as the pulse
  assign busy = draw_start | (state == DB_DRAWING) | (state == DB_SWAP_WAIT);

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= DB_EMPTY;
      front_sel    <= 1'b0;
      frame_done_q <= 1'b0;
      displaying   <= 1'b0;
      swap_count   <= '0;
    end else begin
      frame_done_q <= frame_done;
      front_sel    <= front_sel_nxt;
      case (state)
        DB_EMPTY: begin
          if (draw_start) state <= DB_DRAWING;
        end
        DB_DRAWING: begin
          if (done_rise) state <= DB_SWAP_WAIT;
        end
        DB_SWAP_WAIT: begin
          if (swap) begin
            state      <= DB_SHOWING;
            displaying <= 1'b1;
            swap_count <= swap_count + 1'b1;
          end
        end
        DB_SHOWING: begin
          if (draw_start) state <= DB_DRAWING;
        end
        default: state <= DB_EMPTY;
      endcase
    end
  end

  // writes land in the back buffer
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[~front_sel][wr_addr] <= wr_data;
    end
  end

  // read with the incoming select so pixel (0,0) already comes from the new front
  always_ff @(posedge clk) begin
    rd_data <= mem[front_sel_nxt][rd_addr];
  end

  sel_changes_on_frame_start: assert property (
    @(posedge clk) disable iff (reset)
    (front_sel != $past(front_sel)) |-> $past(frame_start)
  );

  // writer must honor back_locked
  no_write_in_swap_wait: assert property (
    @(posedge clk) disable iff (reset)
    (state == DB_SWAP_WAIT) |-> !wr_en
  );

endmodule

//--- src/fb_writer.sv
`timescale 1ns/1ps

module fb_writer
  import gfx_pixel_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     pix_valid,
  input  coord_x_t pix_x,
  input  coord_y_t pix_y,
  input  pixel_t   pix_color,
  input  logic     pix_last,
  input  logic     back_locked,
  output logic     pix_ready,
  output logic     wr_en,
  output fb_addr_t wr_addr,
  output pixel_t   wr_data,
  output logic     frame_done
);

  logic xfer;
  logic last_q;

  // the write port never stalls, so only the buffer lock holds us off
  assign pix_ready = ~back_locked;
  assign xfer      = pix_valid & pix_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_en      <= 1'b0;
      last_q     <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      wr_en      <= xfer;
      last_q     <= xfer & pix_last;
      // one clock behind the final write so it lands before the swap
      frame_done <= wr_en & last_q;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      wr_addr <= fb_addr_t'(pix_y * FB_WIDTH + pix_x);
      wr_data <= pix_color;
    end
  end

  // pattern source must stay inside the visible frame
  wr_addr_in_range: assert property (
    @(posedge clk) disable iff (reset)
    wr_en |-> (wr_addr < FB_PIXELS)
  );

endmodule

//--- src/gfx_ctrl_pkg.sv
`include "gfx_defines.svh"

package gfx_ctrl_pkg;

  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // encoding 3 is reserved and renders as solid
  typedef logic [1:0] pattern_mode_t;

  localparam pattern_mode_t MODE_SOLID    = 2'd0;
  localparam pattern_mode_t MODE_GRADIENT = 2'd1;
  localparam pattern_mode_t MODE_CHECKER  = 2'd2;

  localparam apb_addr_t ADDR_CTRL   = `GFX_REG_CTRL;
  localparam apb_addr_t ADDR_FILL   = `GFX_REG_FILL;
  localparam apb_addr_t ADDR_STATUS = `GFX_REG_STATUS;

  typedef enum logic {
    GEN_IDLE,
    GEN_EMIT
  } gen_state_t;

  typedef enum logic [1:0] {
    DB_EMPTY,
    DB_DRAWING,
    DB_SWAP_WAIT,
    DB_SHOWING
  } dbuf_state_t;

endpackage

//--- src/gfx_demo.sv
`timescale 1ns/1ps

module gfx_demo
  import gfx_ctrl_pkg::*;
  import gfx_pixel_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  output logic      hsync,
  output logic      vsync,
  output logic      de,
  output channel_t  red,
  output channel_t  grn,
  output channel_t  blu
);

  // register block to generator
  logic          draw_start;
  pattern_mode_t mode;
  pixel_t        fill_color;

  // status back from the buffer controller
  logic          busy;
  logic          displaying;
  logic [7:0]    swap_count;

  // pixel stream
  logic          pix_valid;
  logic          pix_ready;
  coord_x_t      pix_x;
  coord_y_t      pix_y;
  pixel_t        pix_color;
  logic          pix_last;

  // back buffer write port
  logic          wr_en;
  fb_addr_t      wr_addr;
  pixel_t        wr_data;
  logic          frame_done;
  logic          back_locked;

  // front buffer read port
  fb_addr_t      rd_addr;
  pixel_t        rd_data;
  logic          frame_start;

  gfx_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .busy       (busy),
    .displaying (displaying),
    .swap_count (swap_count),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .draw_start (draw_start),
    .mode       (mode),
    .fill_color (fill_color)
  );

  pattern_gen u_pattern (
    .clk        (clk),
    .reset      (reset),
    .draw_start (draw_start),
    .mode       (mode),
    .fill_color (fill_color),
    .pix_ready  (pix_ready),
    .pix_valid  (pix_valid),
    .pix_x      (pix_x),
    .pix_y      (pix_y),
    .pix_color  (pix_color),
    .pix_last   (pix_last)
  );

  fb_writer u_writer (
    .clk         (clk),
    .reset       (reset),
    .pix_valid   (pix_valid),
    .pix_x       (pix_x),
    .pix_y       (pix_y),
    .pix_color   (pix_color),
    .pix_last    (pix_last),
    .back_locked (back_locked),
    .pix_ready   (pix_ready),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .frame_done  (frame_done)
  );

  dbuf_mem u_dbuf (
    .clk         (clk),
    .reset       (reset),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .rd_addr     (rd_addr),
    .frame_start (frame_start),
    .frame_done  (frame_done),
    .draw_start  (draw_start),
    .rd_data     (rd_data),
    .back_locked (back_locked),
    .busy        (busy),
    .displaying  (displaying),
    .swap_count  (swap_count)
  );

  scanout u_scan (
    .clk         (clk),
    .reset       (reset),
    .displaying  (displaying),
    .rd_data     (rd_data),
    .rd_addr     (rd_addr),
    .frame_start (frame_start),
    .hsync       (hsync),
    .vsync       (vsync),
    .de          (de),
    .red         (red),
    .grn         (grn),
    .blu         (blu)
  );

endmodule

//--- src/gfx_pixel_pkg.sv
`include "gfx_defines.svh"

package gfx_pixel_pkg;

  // red in [11:8], green in [7:4], blue in [3:0]
  typedef logic [`GFX_PIXEL_BITS-1:0] pixel_t;
  typedef logic [3:0] channel_t;

  // wide enough for the raster totals, not just the visible area
  typedef logic [4:0] coord_x_t;
  typedef logic [4:0] coord_y_t;

  // y * 16 + x
  typedef logic [7:0] fb_addr_t;

  localparam int unsigned FB_WIDTH  = `GFX_FB_WIDTH;
  localparam int unsigned FB_HEIGHT = `GFX_FB_HEIGHT;
  localparam int unsigned FB_PIXELS = FB_WIDTH * FB_HEIGHT;

endpackage

//--- src/gfx_regs.sv
`timescale 1ns/1ps
`include "gfx_defines.svh"

module gfx_regs
  import gfx_ctrl_pkg::*;
  import gfx_pixel_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          psel,
  input  logic          penable,
  input  logic          pwrite,
  input  apb_addr_t     paddr,
  input  apb_data_t     pwdata,
  input  logic          busy,
  input  logic          displaying,
  input  logic [7:0]    swap_count,
  output apb_data_t     prdata,
  output logic          pready,
  output logic          pslverr,
  output logic          draw_start,
  output pattern_mode_t mode,
  output pixel_t        fill_color
);

  logic access;
  logic wr_access;
  logic sel_ctrl;
  logic sel_fill;
  logic sel_status;
  logic mapped;

  // access phase of an APB transfer
  assign access    = psel & penable;
  assign wr_access = access & pwrite;

  assign sel_ctrl   = (paddr == ADDR_CTRL);
  assign sel_fill   = (paddr == ADDR_FILL);
  assign sel_status = (paddr == ADDR_STATUS);
  assign mapped     = sel_ctrl | sel_fill | sel_status;

  // no wait states
  assign pready = 1'b1;

  // STATUS is read only
  assign pslverr = access & (~mapped | (pwrite & sel_status));

  always_ff @(posedge clk) begin
    if (reset) begin
      mode       <= MODE_SOLID;
      fill_color <= '0;
      draw_start <= 1'b0;
    end else begin
      // draw request dropped while a frame is still in flight
      draw_start <= wr_access & sel_ctrl & pwdata[0] & ~busy;
      if (wr_access && sel_ctrl) begin
        mode <= pattern_mode_t'(pwdata[2:1]);
      end
      if (wr_access && sel_fill) begin
        fill_color <= pwdata[`GFX_PIXEL_BITS-1:0];
      end
    end
  end

  // draw bit is self clearing, so it reads back as 0
  always_comb begin
    prdata = '0;
    if (sel_ctrl) begin
      prdata[2:1] = mode;
    end else if (sel_fill) begin
      prdata[`GFX_PIXEL_BITS-1:0] = fill_color;
    end else if (sel_status) begin
      prdata[0]    = busy;
      prdata[1]    = displaying;
      prdata[15:8] = swap_count;
    end
  end

  // busy from the buffer controller must block a back-to-back draw
  draw_single_cycle: assert property (
    @(posedge clk) disable iff (reset)
    draw_start |=> !draw_start
  );

endmodule

//--- src/pattern_gen.sv
`timescale 1ns/1ps

module pattern_gen
  import gfx_ctrl_pkg::*;
  import gfx_pixel_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          draw_start,
  input  pattern_mode_t mode,
  input  pixel_t        fill_color,
  input  logic          pix_ready,
  output logic          pix_valid,
  output coord_x_t      pix_x,
  output coord_y_t      pix_y,
  output pixel_t        pix_color,
  output logic          pix_last
);

  gen_state_t    state;
  pattern_mode_t mode_q;
  pixel_t        fill_q;
  logic          xfer;
  logic          x_end;
  channel_t      grad_red;
  channel_t      grad_grn;

  assign pix_valid = (state == GEN_EMIT);
  assign xfer      = pix_valid & pix_ready;
  assign x_end     = (pix_x == coord_x_t'(FB_WIDTH - 1));
  assign pix_last  = x_end & (pix_y == coord_y_t'(FB_HEIGHT - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= GEN_IDLE;
      pix_x <= '0;
      pix_y <= '0;
    end else begin
      case (state)
        GEN_IDLE: begin
          if (draw_start) begin
            state <= GEN_EMIT;
            pix_x <= '0;
            pix_y <= '0;
          end
        end
        GEN_EMIT: begin
          // raster order, x first
          if (xfer) begin
            if (pix_last) begin
              state <= GEN_IDLE;
            end else if (x_end) begin
              pix_x <= '0;
              pix_y <= pix_y + 1'b1;
            end else begin
              pix_x <= pix_x + 1'b1;
            end
          end
        end
        default: state <= GEN_IDLE;
      endcase
    end
  end

  // settings are frozen for the whole frame
  always_ff @(posedge clk) begin
    if (draw_start && state == GEN_IDLE) begin
      mode_q <= mode;
      fill_q <= fill_color;
    end
  end

  assign grad_red = channel_t'(pix_x);
  assign grad_grn = channel_t'(pix_y);

  always_comb begin
    pix_color = fill_q;
    case (mode_q)
      MODE_SOLID:    pix_color = fill_q;
      MODE_GRADIENT: pix_color = {grad_red, grad_grn, fill_q[3:0]};
      // 4x4 tiles
      MODE_CHECKER:  pix_color = (pix_x[2] ^ pix_y[2]) ? ~fill_q : fill_q;
      default:       pix_color = fill_q;
    endcase
  end

endmodule

//--- src/scanout.sv
`timescale 1ns/1ps
`include "gfx_defines.svh"

module scanout
  import gfx_pixel_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     displaying,
  input  pixel_t   rd_data,
  output fb_addr_t rd_addr,
  output logic     frame_start,
  output logic     hsync,
  output logic     vsync,
  output logic     de,
  output channel_t red,
  output channel_t grn,
  output channel_t blu
);

  coord_x_t h_cnt;
  coord_y_t v_cnt;
  logic     h_end;
  logic     v_end;
  logic     visible;
  logic     show;

  assign h_end   = (h_cnt == coord_x_t'(`GFX_H_TOTAL - 1));
  assign v_end   = (v_cnt == coord_y_t'(`GFX_V_TOTAL - 1));
  assign visible = (h_cnt < FB_WIDTH) && (v_cnt < FB_HEIGHT);

  assign frame_start = (h_cnt == '0) && (v_cnt == '0);

  // free running raster
  always_ff @(posedge clk) begin
    if (reset) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_end) begin
      h_cnt <= '0;
      v_cnt <= v_end ? '0 : v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // outside the visible area the address parks at 0
  assign rd_addr = visible ? fb_addr_t'(v_cnt * FB_WIDTH + h_cnt) : '0;

  // sync and de delayed one clock to line up with rd_data
  always_ff @(posedge clk) begin
    if (reset) begin
      hsync <= 1'b0;
      vsync <= 1'b0;
      de    <= 1'b0;
    end else begin
      hsync <= (h_cnt >= coord_x_t'(`GFX_H_SYNC_START)) &&
               (h_cnt < coord_x_t'(`GFX_H_SYNC_END));
      vsync <= (v_cnt == coord_y_t'(`GFX_V_SYNC_LINE));
      de    <= visible;
    end
  end

  // black until the first buffer swap
  assign show = de & displaying;

  assign red = show ? rd_data[11:8] : '0;
  assign grn = show ? rd_data[7:4]  : '0;
  assign blu = show ? rd_data[3:0]  : '0;

endmodule

//--- verification/tb_gfx_demo.sv
`timescale 1ns/1ps
`include "gfx_defines.svh"

module tb_gfx_demo
  import gfx_ctrl_pkg::*;
  import gfx_pixel_pkg::*;
();

  localparam realtime CLK_PERIOD = 100.0;
  localparam int FRAME_CLKS = `GFX_H_TOTAL * `GFX_V_TOTAL;
  // 20 frames of display plus room for the register traffic
  localparam int TIMEOUT_CLKS = 20 * FRAME_CLKS + 2000;
  localparam int CHK_STRICT = 1;
  localparam int CHK_EITHER = 2;

  logic      clk;
  logic      reset;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      hsync;
  logic      vsync;
  logic      de;
  channel_t  red;
  channel_t  grn;
  channel_t  blu;

  int    error_count;
  string test_name;
  int    frames_done;
  int    swaps_expected;

  // expected image for upcoming frames, taken over at each vsync
  int            next_kind;
  pattern_mode_t next_mode;
  pixel_t        next_fill;
  pattern_mode_t next_alt_mode;
  pixel_t        next_alt_fill;
  int            cur_kind;
  pattern_mode_t cur_mode;
  pixel_t        cur_fill;
  pattern_mode_t cur_alt_mode;
  pixel_t        cur_alt_fill;

  logic vsync_q;
  logic hsync_q;
  logic de_q;
  logic have_sync;
  int   clk_cnt;
  int   hs_rises;
  int   de_lines;
  int   de_run;
  int   pix_cnt;
  logic match_a;
  logic match_b;

  gfx_demo dut0 (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .hsync   (hsync),
    .vsync   (vsync),
    .de      (de),
    .red     (red),
    .grn     (grn),
    .blu     (blu)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic pixel_t expected_pixel(input pattern_mode_t mode, input pixel_t fill,
                                            input int x, input int y);
    pixel_t color;
    case (mode)
      2'd1: color = {x[3:0], y[3:0], fill[3:0]};
      // 4x4 tiles, inverted on odd tiles
      2'd2: color = (x[2] ^ y[2]) ? ~fill : fill;
      default: color = fill;
    endcase
    return color;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    err = pslverr;
    check_value("pready on write", 1, 32'(pready));
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    check_value("pready on read", 1, 32'(pready));
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic expect_image(input int kind, input pattern_mode_t mode, input pixel_t fill,
                              input pattern_mode_t alt_mode, input pixel_t alt_fill);
    next_kind     = kind;
    next_mode     = mode;
    next_fill     = fill;
    next_alt_mode = alt_mode;
    next_alt_fill = alt_fill;
  endtask

  task automatic wait_frames(input int count);
    int target;
    target = frames_done + count;
    while (frames_done < target) @(posedge clk);
  endtask

  // old image stays acceptable until the swap, then only the new one
  task automatic draw_image(input string name, input pattern_mode_t mode, input pixel_t fill,
                            input pattern_mode_t old_mode, input pixel_t old_fill,
                            input logic extra_request);
    apb_data_t rdata;
    logic      err;
    test_name = name;
    expect_image(CHK_EITHER, old_mode, old_fill, mode, fill);
    apb_write(ADDR_FILL, 32'(fill), err);
    check_value({name, " fill write error"}, 0, 32'(err));
    apb_write(ADDR_CTRL, {29'b0, mode, 1'b1}, err);
    // one swap per accepted draw
    swaps_expected++;
    apb_read(ADDR_STATUS, rdata, err);
    check_value({name, " busy after draw"}, 1, 32'(rdata[0]));
    if (extra_request) begin
      // busy is high, so this request must be dropped
      apb_write(ADDR_CTRL, {29'b0, mode, 1'b1}, err);
    end
    rdata = 32'h1;
    while (rdata[0]) apb_read(ADDR_STATUS, rdata, err);
    check_value({name, " displaying"}, 1, 32'(rdata[1]));
    check_value({name, " swap count"}, swaps_expected, 32'(rdata[15:8]));
    expect_image(CHK_STRICT, mode, fill, mode, fill);
    wait_frames(2);
    apb_read(ADDR_STATUS, rdata, err);
    check_value({name, " swap count later"}, swaps_expected, 32'(rdata[15:8]));
    apb_read(ADDR_CTRL, rdata, err);
    check_value({name, " ctrl readback"}, {29'b0, mode, 1'b0}, rdata);
  endtask

  // rebuild x and y from de after each vsync and compare every pixel
  always @(negedge clk) begin : monitor
    pixel_t seen;
    int     x;
    int     y;
    if (reset) begin
      have_sync = 1'b0;
      vsync_q   = 1'b0;
      hsync_q   = 1'b0;
      de_q      = 1'b0;
      clk_cnt   = 0;
      hs_rises  = 0;
      de_lines  = 0;
      de_run    = 0;
      pix_cnt   = 0;
    end else begin
      clk_cnt++;
      if (hsync && !hsync_q) hs_rises++;
      if (de && !de_q) de_lines++;
      if (de) de_run++;
      if (!de && de_q) begin
        if (have_sync) check_value("de clocks per line", 16, de_run);
        de_run = 0;
      end
      if (vsync && !vsync_q) begin
        if (have_sync) begin
          check_value("clocks per frame", FRAME_CLKS, clk_cnt);
          check_value("hsync pulses per frame", `GFX_V_TOTAL, hs_rises);
          check_value("de lines per frame", `GFX_FB_HEIGHT, de_lines);
        end
        have_sync    = 1'b1;
        clk_cnt      = 0;
        hs_rises     = 0;
        de_lines     = 0;
        pix_cnt      = 0;
        match_a      = 1'b1;
        match_b      = 1'b1;
        cur_kind     = next_kind;
        cur_mode     = next_mode;
        cur_fill     = next_fill;
        cur_alt_mode = next_alt_mode;
        cur_alt_fill = next_alt_fill;
      end
      if (de && have_sync && pix_cnt < FB_PIXELS) begin
        x    = pix_cnt % FB_WIDTH;
        y    = pix_cnt / FB_WIDTH;
        seen = {red, grn, blu};
        if (cur_kind == CHK_STRICT) begin
          check_value(test_name, 32'(expected_pixel(cur_mode, cur_fill, x, y)), 32'(seen));
        end else begin
          match_a = match_a & (seen === expected_pixel(cur_mode, cur_fill, x, y));
          match_b = match_b & (seen === expected_pixel(cur_alt_mode, cur_alt_fill, x, y));
        end
        pix_cnt++;
        if (pix_cnt == FB_PIXELS) begin
          if (cur_kind == CHK_EITHER) begin
            check_value({test_name, " whole frame"}, 1, 32'(match_a | match_b));
          end
          frames_done++;
        end
      end
      vsync_q = vsync;
      hsync_q = hsync;
      de_q    = de;
    end
  end

  initial begin : watchdog
    #(TIMEOUT_CLKS * CLK_PERIOD);
    $display("timeout: the tests did not finish in the allowed simulation time");
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    apb_data_t rdata;
    logic      err;
    pixel_t    fill_a;
    pixel_t    fill_b;
    pixel_t    fill_c;
    pixel_t    fill_d;
    int        seed_ret;
    clk            = 1'b0;
    reset          = 1'b1;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    error_count    = 0;
    frames_done    = 0;
    swaps_expected = 0;
    test_name      = "blank display";
    // black screen until the first swap
    expect_image(CHK_STRICT, MODE_SOLID, '0, MODE_SOLID, '0);
    seed_ret = $urandom(77);
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    apb_read(ADDR_STATUS, rdata, err);
    check_value("status after reset", 0, rdata);
    check_value("status read error", 0, 32'(err));
    fill_a = pixel_t'($urandom);
    apb_write(ADDR_FILL, 32'(fill_a), err);
    apb_read(ADDR_FILL, rdata, err);
    check_value("fill readback", 32'(fill_a), rdata);
    apb_write(ADDR_CTRL, 32'h4, err);
    apb_read(ADDR_CTRL, rdata, err);
    check_value("ctrl mode readback", 32'h4, rdata);
    apb_read(8'h0C, rdata, err);
    check_value("unmapped read error", 1, 32'(err));
    apb_write(ADDR_STATUS, 32'hffff, err);
    check_value("status write error", 1, 32'(err));

    wait_frames(2);

    draw_image("solid draw", MODE_SOLID, fill_a, MODE_SOLID, '0, 1'b0);
    fill_b = pixel_t'($urandom);
    draw_image("gradient draw", MODE_GRADIENT, fill_b, MODE_SOLID, fill_a, 1'b0);
    fill_c = pixel_t'($urandom);
    draw_image("checker draw", MODE_CHECKER, fill_c, MODE_GRADIENT, fill_b, 1'b0);
    fill_d = pixel_t'($urandom);
    draw_image("tear-free swap", MODE_GRADIENT, fill_d, MODE_CHECKER, fill_c, 1'b1);

    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
